//--- dfe_tap_adapt.f
+incdir+hdl
hdl/dfe_tap_adapt_pkg.sv
hdl/testbus_sync.sv
hdl/tap_histogram.sv
hdl/adapt_sequencer.sv
hdl/dfe_tap_adapt.sv
sim/reg_target_model.sv
sim/tb_dfe_tap_adapt.sv

//--- hdl/adapt_sequencer.sv
`timescale 1ns/10ps
`include "dfe_tap_adapt_defines.svh"

module adapt_sequencer
    import dfe_tap_adapt_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  uif_req_t  uif,
    output logic      uif_busy,
    output ctrl_req_t ctrl_req,
    input  ctrl_rsp_t ctrl_rsp,
    output pass_t     pass,
    output logic      hist_clear,
    output logic      hist_run,
    input  logic      init_done,
    input  logic      pass_done,
    input  logic      final_pass_done,
    input  tap_set_t  taps
);

    adapt_state_t state;
    adapt_state_t next_state;
    logic         start;
    logic         go_next;
    logic         go_ff;
    logic         go_q;
    logic         lock;
    reg_data_t    saved_reg13;
    ctrl_op_t     opcode;
    reg_addr_t    addr;
    reg_data_t    wdata;

    assign start = uif.go && (uif.mode == uif_mode_wr) && (uif.addr == `DFE_OFFSET_TAP_ADAPT);

    // ----------------------------------------------------------
    // state machine, every bus state waits for done
    // ----------------------------------------------------------
    always_comb
    begin
        next_state = state;
        go_next    = 1'b0;
        case (state)
            st_idle:        if (start) begin next_state = st_adapt_on; go_next = 1'b1; end
            st_adapt_on:    if (ctrl_rsp.done)
                            begin
                                next_state = ctrl_rsp.chan_err ? st_idle : st_bypass_rd;
                                go_next    = !ctrl_rsp.chan_err;
                            end
            st_bypass_rd:   if (ctrl_rsp.done) begin next_state = st_bypass_wr; go_next = 1'b1; end
            st_bypass_wr:   if (ctrl_rsp.done) begin next_state = st_testbus_sel; go_next = 1'b1; end
            st_testbus_sel: if (ctrl_rsp.done) next_state = st_ram_init;
            st_ram_init:    if (init_done) next_state = st_ram_wr;
            st_ram_wr:      if (final_pass_done) begin next_state = st_wr_reg11; go_next = 1'b1; end
                            else if (pass_done) begin next_state = st_testbus_sel; go_next = 1'b1; end
            st_wr_reg11:    if (ctrl_rsp.done) begin next_state = st_wr_reg13; go_next = 1'b1; end
            st_wr_reg13:    if (ctrl_rsp.done) next_state = st_idle;
            default:        next_state = st_idle;
        endcase
    end

    // go lags the state change by one stage so the payload settles first
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= st_idle;
            go_ff <= 1'b0;
            go_q  <= 1'b0;
        end
        else
        begin
            state <= next_state;
            go_ff <= go_next;
            go_q  <= go_ff;
        end
    end

    // register 13 as found, restored at the end
    always_ff @(posedge clk)
    begin
        if ((state == st_bypass_rd) && ctrl_rsp.done)
            saved_reg13 <= ctrl_rsp.rdata;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            pass <= 3'b001;
        else if (state == st_idle)
            pass <= 3'b001;
        else if (pass_done)
            pass <= {pass[1:0], 1'b0};
    end

    // ----------------------------------------------------------
    // transaction payload
    // ----------------------------------------------------------
    always_comb
    begin
        opcode = ctrl_op_rd;
        addr   = '0;
        wdata  = '0;
        case (state)
            st_adapt_on:
            begin
                opcode               = ctrl_op_wr;
                addr                 = `DFE_REG11_ADDR;
                wdata[`DFE_ADAPT_BIT] = 1'b1;
            end
            st_bypass_rd:   addr = `DFE_REG13_ADDR;
            st_bypass_wr:
            begin
                opcode                = ctrl_op_wr;
                addr                  = `DFE_REG13_ADDR;
                wdata                 = saved_reg13;
                wdata[`DFE_BYPASS_BIT] = 1'b0;
            end
            st_testbus_sel:
            begin
                opcode = ctrl_op_tbus;
                case (pass)
                    3'b001:  wdata = `TESTBUS_SEL_1;
                    3'b010:  wdata = `TESTBUS_SEL_2;
                    3'b100:  wdata = `TESTBUS_SEL_3;
                    default: wdata = '0;
                endcase
            end
            st_wr_reg11:
            begin
                // adapt bit stays low
                opcode                   = ctrl_op_wr;
                addr                     = `DFE_REG11_ADDR;
                wdata[`DFE_TAP1_LSB +: 4] = taps.tap1;
                wdata[`DFE_TAP2_LSB +: 3] = taps.tap2;
                wdata[`DFE_TAP3_LSB +: 3] = taps.tap3;
                wdata[`DFE_TAP4_LSB +: 3] = taps.tap4;
                wdata[`DFE_TAP5_LSB +: 2] = taps.tap5;
            end
            st_wr_reg13:
            begin
                opcode                = ctrl_op_wr;
                addr                  = `DFE_REG13_ADDR;
                wdata                 = saved_reg13;
                wdata[`DFE_BYPASS_BIT] = 1'b1;
                wdata[`DFE_T2INV_BIT]  = taps.tap2_inv;
                wdata[`DFE_T3INV_BIT]  = taps.tap3_inv;
                wdata[`DFE_T4INV_BIT]  = taps.tap4_inv;
                wdata[`DFE_T5INV_BIT]  = taps.tap5_inv;
            end
            default: ;
        endcase
    end

    assign lock = state inside {st_bypass_rd, st_bypass_wr, st_testbus_sel,
                                st_ram_init, st_ram_wr, st_wr_reg11};

    assign ctrl_req   = '{go: go_q, opcode: opcode, lock: lock, addr: addr, wdata: wdata};
    assign uif_busy   = (state != st_idle);
    assign hist_clear = (state == st_ram_init);
    assign hist_run   = (state == st_ram_wr);

    // go is a single-cycle strobe
    assert property (@(posedge clk) disable iff (reset) go_q |=> !go_q);
    // no bus traffic outside a run
    assert property (@(posedge clk) disable iff (reset) go_q |-> (state != st_idle));

endmodule

//--- hdl/dfe_tap_adapt.sv
`timescale 1ns/10ps

module dfe_tap_adapt
    import dfe_tap_adapt_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  uif_req_t  uif,
    output logic      uif_busy,
    output ctrl_req_t ctrl_req,
    input  ctrl_rsp_t ctrl_rsp,
    input  testbus_t  ctrl_testbus
);

    pass_t    pass;
    logic     hist_clear;
    logic     hist_run;
    logic     init_done;
    logic     pass_done;
    logic     final_pass_done;
    tap_set_t taps;
    testbus_t testbus_sample;

    adapt_sequencer u_sequencer (
        .clk             (clk),
        .reset           (reset),
        .uif             (uif),
        .uif_busy        (uif_busy),
        .ctrl_req        (ctrl_req),
        .ctrl_rsp        (ctrl_rsp),
        .pass            (pass),
        .hist_clear      (hist_clear),
        .hist_run        (hist_run),
        .init_done       (init_done),
        .pass_done       (pass_done),
        .final_pass_done (final_pass_done),
        .taps            (taps)
    );

    testbus_sync u_testbus_sync (
        .clk            (clk),
        .ctrl_testbus   (ctrl_testbus),
        .testbus_sample (testbus_sample)
    );

    tap_histogram u_tap_histogram (
        .clk             (clk),
        .reset           (reset),
        .uif             (uif),
        .pass            (pass),
        .hist_clear      (hist_clear),
        .hist_run        (hist_run),
        .testbus_sample  (testbus_sample),
        .init_done       (init_done),
        .pass_done       (pass_done),
        .final_pass_done (final_pass_done),
        .taps            (taps)
    );

endmodule

//--- hdl/dfe_tap_adapt_defines.svh
`ifndef DFE_TAP_ADAPT_DEFINES_SVH
`define DFE_TAP_ADAPT_DEFINES_SVH

// user offsets
`define DFE_OFFSET_TAP_ADAPT   6'h0c
`define DFE_OFFSET_ADAPT_WAIT  6'h0d
`define DFE_OFFSET_ADAPT_COUNT 6'h0e

// control bus addresses of the dfe registers
`define DFE_REG11_ADDR 12'h00b
`define DFE_REG13_ADDR 12'h00d

// register 11 fields, tap widths 4/3/3/3/2
`define DFE_TAP1_LSB  0
`define DFE_TAP2_LSB  4
`define DFE_TAP3_LSB  7
`define DFE_TAP4_LSB  10
`define DFE_TAP5_LSB  13
`define DFE_ADAPT_BIT 15

// register 13 bypass and polarity bits
`define DFE_BYPASS_BIT 0
`define DFE_T2INV_BIT  9
`define DFE_T3INV_BIT  10
`define DFE_T4INV_BIT  11
`define DFE_T5INV_BIT  12

// test bus views, one per pass
`define TESTBUS_SEL_1 16'h0009
`define TESTBUS_SEL_2 16'h000a
`define TESTBUS_SEL_3 16'h000b

`define DEFAULT_REG_WAIT  8'd55
`define DEFAULT_REG_COUNT 10'd200

`endif

//--- hdl/dfe_tap_adapt_pkg.sv
package dfe_tap_adapt_pkg;

    // ----------------------------------------------------------
    // plain vectors
    // ----------------------------------------------------------
    typedef logic [15:0] reg_data_t;
    typedef logic [11:0] reg_addr_t;
    typedef logic [5:0]  uif_addr_t;
    typedef logic [7:0]  testbus_t;
    typedef logic [3:0]  tap_code_t;    // sign in the msb
    typedef logic [9:0]  hist_count_t;
    typedef logic [4:0]  hist_addr_t;   // odd/even select + tap code
    typedef logic [7:0]  wait_t;
    typedef logic [2:0]  pass_t;        // one-hot

    typedef enum logic [2:0] {
        ctrl_op_rd   = 3'b000,
        ctrl_op_wr   = 3'b001,
        ctrl_op_tbus = 3'b011
    } ctrl_op_t;

    typedef enum logic [2:0] {
        uif_mode_rd   = 3'b000,
        uif_mode_wr   = 3'b001,
        uif_mode_phys = 3'b010
    } uif_mode_t;

    typedef enum logic [3:0] {
        st_idle, st_adapt_on, st_bypass_rd, st_bypass_wr, st_testbus_sel,
        st_ram_init, st_ram_wr, st_wr_reg11, st_wr_reg13
    } adapt_state_t;

    // ----------------------------------------------------------
    // bus bundles
    // ----------------------------------------------------------
    typedef struct packed {
        logic      go;
        uif_mode_t mode;
        uif_addr_t addr;
        reg_data_t wdata;
    } uif_req_t;

    typedef struct packed {
        logic go;
        ctrl_op_t opcode;
        logic lock;
        reg_addr_t addr;
        reg_data_t wdata;
    } ctrl_req_t;

    typedef struct packed {
        logic      done;
        logic      chan_err;
        reg_data_t rdata;
    } ctrl_rsp_t;

    typedef struct packed {
        logic [3:0] tap1;
        logic [2:0] tap2;
        logic [2:0] tap3;
        logic [2:0] tap4;
        logic [1:0] tap5;
        logic       tap2_inv;
        logic       tap3_inv;
        logic       tap4_inv;
        logic       tap5_inv;
    } tap_set_t;

endpackage

//--- hdl/tap_histogram.sv
`timescale 1ns/10ps
`include "dfe_tap_adapt_defines.svh"

module tap_histogram
    import dfe_tap_adapt_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  uif_req_t uif,
    input  pass_t    pass,
    input  logic     hist_clear,
    input  logic     hist_run,
    input  testbus_t testbus_sample,
    output logic     init_done,
    output logic     pass_done,
    output logic     final_pass_done,
    output tap_set_t taps
);

    wait_t       reg_wait;
    hist_count_t reg_count;
    wait_t       wait_ctr;
    logic        sample_go;
    logic [5:0]  ram_ctrl;
    tap_code_t   odd_tap;
    tap_code_t   even_tap;
    hist_addr_t  clr_addr;
    hist_addr_t  ram_addr;
    hist_count_t hist_ram [0:31];
    hist_count_t ram_dout;
    hist_count_t ram_din;
    logic        ram_stop;
    logic        odd_done;
    logic        even_done;

    // ----------------------------------------------------------
    // user registers and sample timer
    // ----------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            reg_wait  <= `DEFAULT_REG_WAIT;
            reg_count <= `DEFAULT_REG_COUNT;
        end
        else if (uif.go && (uif.mode == uif_mode_wr))
        begin
            if (uif.addr == `DFE_OFFSET_ADAPT_WAIT)
                reg_wait <= uif.wdata[7:0];
            if (uif.addr == `DFE_OFFSET_ADAPT_COUNT)
                reg_count <= uif.wdata[9:0];
        end
    end

    // one sample every wait+1 cycles
    assign sample_go = hist_run && (wait_ctr == reg_wait);

    always_ff @(posedge clk)
    begin
        if (reset || !hist_run || sample_go)
            wait_ctr <= '0;
        else
            wait_ctr <= wait_ctr + 1'b1;
        // flushed outside the run phase
        if (reset || !hist_run)
            ram_ctrl <= '0;
        else
            ram_ctrl <= {ram_ctrl[4:0], sample_go};
    end

    // ----------------------------------------------------------
    // odd/even split per pass
    // ----------------------------------------------------------
    always_comb
    begin
        odd_tap  = '0;
        even_tap = '0;
        case (pass)
            3'b001: begin odd_tap = testbus_sample[7:4];
                          even_tap = {testbus_sample[0], testbus_sample[3:1]}; end
            3'b010: begin odd_tap = {testbus_sample[1], testbus_sample[7:5]};
                          even_tap = {testbus_sample[0], testbus_sample[4:2]}; end
            3'b100: odd_tap = {1'b0, testbus_sample[5], testbus_sample[7:6]};
            default: ;
        endcase
    end

    // ----------------------------------------------------------
    // histogram ram, read-increment-write, odd then even
    // ----------------------------------------------------------
    always_ff @(posedge clk)
    begin
        clr_addr <= hist_clear ? clr_addr + 1'b1 : '0;
        if (ram_ctrl[0] || ram_ctrl[2])
            ram_addr <= {ram_ctrl[2], (ram_ctrl[2] ? even_tap : odd_tap)};
        ram_din <= ram_dout + 1'b1;
        if (hist_clear)
            hist_ram[clr_addr] <= '0;
        else if (ram_ctrl[2] || ram_ctrl[4])
            hist_ram[ram_addr] <= ram_din;
    end

    assign ram_dout  = hist_ram[ram_addr];
    assign ram_stop  = (ram_din == reg_count);
    assign init_done = hist_clear && (&clr_addr);

    // first bin to reach the limit wins
    always_ff @(posedge clk)
    begin
        if (reset || hist_clear)
        begin
            odd_done  <= 1'b0;
            even_done <= 1'b0;
        end
        else
        begin
            if (ram_stop && ram_ctrl[2])
                odd_done <= 1'b1;
            if (ram_stop && ram_ctrl[4])
                even_done <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (hist_run && ram_stop && ram_ctrl[2] && !odd_done)
            case (pass)
                3'b001:  taps.tap1 <= ram_addr[3:0];
                3'b010:  {taps.tap3_inv, taps.tap3} <= ram_addr[3:0];
                3'b100:  {taps.tap5_inv, taps.tap5} <= ram_addr[2:0];
                default: ;
            endcase
        if (hist_run && ram_stop && ram_ctrl[4] && !even_done)
            case (pass)
                3'b001:  {taps.tap2_inv, taps.tap2} <= ram_addr[3:0];
                3'b010:  {taps.tap4_inv, taps.tap4} <= ram_addr[3:0];
                default: ;
            endcase
    end

    // last pass has no even tap
    assign pass_done       = hist_run && ram_ctrl[5] && odd_done && even_done && !pass[2];
    assign final_pass_done = hist_run && ram_ctrl[5] && odd_done && pass[2];

    assert property (@(posedge clk) disable iff (reset) hist_run |-> $onehot(pass));

endmodule

//--- hdl/testbus_sync.sv
`timescale 1ns/10ps

module testbus_sync
    import dfe_tap_adapt_pkg::*;
(
    input  logic     clk,
    input  testbus_t ctrl_testbus,
    output testbus_t testbus_sample
);

    testbus_t   sync_ff [4];
    logic [2:0] stable_hist;
    logic       same;
    logic       load;

    // async byte into the clock domain
    always_ff @(posedge clk)
    begin
        sync_ff[0] <= ctrl_testbus;
        for (int i = 1; i < 4; i++)
            sync_ff[i] <= sync_ff[i-1];
    end

    assign same = (sync_ff[3] == sync_ff[2]);

    // four matching compares in a row before a load
    assign load = (&stable_hist) && same;

    always_ff @(posedge clk)
    begin
        stable_hist <= {stable_hist[1:0], same};
        if (load)
            testbus_sample <= sync_ff[3];
    end

endmodule

//--- sim/reg_target_model.sv
`timescale 1ns/10ps
`include "dfe_tap_adapt_defines.svh"

module reg_target_model
    import dfe_tap_adapt_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  ctrl_req_t   ctrl_req,
    output ctrl_rsp_t   ctrl_rsp,
    output testbus_t    ctrl_testbus,
    input  reg_data_t   reg13_preset,
    input  logic [23:0] testbus_bytes,
    input  logic        err_on_adapt
);

    ctrl_req_t pending;
    logic      open;
    int        delay;
    int        log_count;
    int        overlap_count;
    ctrl_op_t  log_op [64];
    reg_addr_t log_addr [64];
    reg_data_t log_wdata [64];
    logic      log_lock [64];

    initial
    begin
        ctrl_rsp      = '0;
        ctrl_testbus  = '0;
        open          = 1'b0;
        delay         = 0;
        log_count     = 0;
        overlap_count = 0;
    end

    // ----------------------------------------------------------
    // one transaction at a time with done after 1 to 6 cycles
    // ----------------------------------------------------------
    always @(posedge clk)
    begin
        ctrl_rsp <= '0;
        if (reset)
            open <= 1'b0;
        else if (ctrl_req.go)
        begin
            if (open)
                overlap_count <= overlap_count + 1;
            pending <= ctrl_req;
            open    <= 1'b1;
            delay   <= 1 + ($urandom % 6);
            if (log_count < 64)
            begin
                log_op[log_count]    <= ctrl_req.opcode;
                log_addr[log_count]  <= ctrl_req.addr;
                log_wdata[log_count] <= ctrl_req.wdata;
                log_lock[log_count]  <= ctrl_req.lock;
            end
            log_count <= log_count + 1;
        end
        else if (open)
        begin
            if (delay > 1)
                delay <= delay - 1;
            else
            begin
                open          <= 1'b0;
                ctrl_rsp.done <= 1'b1;
                if ((pending.opcode == ctrl_op_rd) && (pending.addr == `DFE_REG13_ADDR))
                    ctrl_rsp.rdata <= reg13_preset;
                // only the adapt-on write can be refused
                ctrl_rsp.chan_err <= err_on_adapt && (pending.opcode == ctrl_op_wr)
                                     && (pending.addr == `DFE_REG11_ADDR)
                                     && pending.wdata[`DFE_ADAPT_BIT];
                if (pending.opcode == ctrl_op_tbus)
                    case (pending.wdata)
                        16'd9:   ctrl_testbus <= testbus_bytes[7:0];
                        16'd10:  ctrl_testbus <= testbus_bytes[15:8];
                        16'd11:  ctrl_testbus <= testbus_bytes[23:16];
                        default: ;
                    endcase
            end
        end
    end

endmodule

//--- sim/tb_dfe_tap_adapt.sv
`timescale 1ns/10ps
`include "dfe_tap_adapt_defines.svh"

module tb_dfe_tap_adapt
    import dfe_tap_adapt_pkg::*;
();

    // worst case per run is at the reset count of 200 and wait of 55
    localparam int RUNS            = 5;
    localparam int WATCHDOG_CYCLES = RUNS * (3 * (200 + 1) * 2 * (55 + 8) + 32 * 3 + 200);

    logic        clk;
    logic        reset;
    uif_req_t    uif;
    logic        uif_busy;
    ctrl_req_t   ctrl_req;
    ctrl_rsp_t   ctrl_rsp;
    testbus_t    ctrl_testbus;
    reg_data_t   reg13_preset;
    logic [23:0] testbus_bytes;
    logic        err_on_adapt;

    reg_data_t   exp_reg11;
    reg_data_t   exp_reg13;
    int          log_base;
    string       check_name;
    logic        check_req;
    int unsigned seed;
    int unsigned rnd;
    int          default_cycles;
    int          short_cycles;
    int          cycles;

    dfe_tap_adapt uut (
        .clk          (clk),
        .reset        (reset),
        .uif          (uif),
        .uif_busy     (uif_busy),
        .ctrl_req     (ctrl_req),
        .ctrl_rsp     (ctrl_rsp),
        .ctrl_testbus (ctrl_testbus)
    );

    reg_target_model target (
        .clk           (clk),
        .reset         (reset),
        .ctrl_req      (ctrl_req),
        .ctrl_rsp      (ctrl_rsp),
        .ctrl_testbus  (ctrl_testbus),
        .reg13_preset  (reg13_preset),
        .testbus_bytes (testbus_bytes),
        .err_on_adapt  (err_on_adapt)
    );

    always #4 clk = ~clk;

    // ----------------------------------------------------------
    // reference, compare and bus helpers
    // ----------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // expected {register 11, register 13} final writes from the three views
    function automatic logic [31:0] reference_writes(input logic [23:0] bytes,
                                                     input reg_data_t preset);
        testbus_t  b1;
        testbus_t  b2;
        testbus_t  b3;
        reg_data_t r11;
        reg_data_t r13;
        b1 = bytes[7:0];
        b2 = bytes[15:8];
        b3 = bytes[23:16];
        r11        = '0;
        r11[3:0]   = b1[7:4];
        r11[6:4]   = b1[3:1];
        r11[9:7]   = b2[7:5];
        r11[12:10] = b2[4:2];
        r11[14:13] = b3[7:6];
        r13        = preset;
        r13[0]     = 1'b1;
        r13[9]     = b1[0];
        r13[10]    = b2[1];
        r13[11]    = b2[0];
        r13[12]    = b3[5];
        return {r11, r13};
    endfunction

    function automatic reg_data_t logged_wdata(input int idx);
        return target.log_wdata[log_base + idx];
    endfunction

    task automatic check_entry(input string name, input int idx, input ctrl_op_t op,
                               input reg_addr_t addr);
        check_value({name, " opcode"}, op, target.log_op[log_base + idx]);
        check_value({name, " address"}, addr, target.log_addr[log_base + idx]);
    endtask

    task automatic user_write(input uif_addr_t addr, input reg_data_t data);
        @(posedge clk);
        uif <= '{go: 1'b1, mode: uif_mode_wr, addr: addr, wdata: data};
        @(posedge clk);
        uif <= '0;
    endtask

    task automatic load_random(input logic [23:0] sign_bits);
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = $urandom;
        r2 = $urandom;
        @(posedge clk);
        testbus_bytes <= r1[23:0] | sign_bits;
        reg13_preset  <= r2[15:0];
        {exp_reg11, exp_reg13} = reference_writes(r1[23:0] | sign_bits, r2[15:0]);
    endtask

    task automatic run_adapt(input string name, output int run_cycles);
        logic prev_done;
        log_base = target.log_count;
        user_write(`DFE_OFFSET_TAP_ADAPT, 16'h0000);
        @(negedge clk);
        check_value({name, " busy rise"}, 1, uif_busy);
        run_cycles = 0;
        prev_done  = 1'b0;
        while (uif_busy)
        begin
            prev_done = ctrl_rsp.done;
            @(negedge clk);
            run_cycles++;
        end
        // busy drops the cycle after the last done
        check_value({name, " busy fall"}, 1, prev_done);
        check_name = name;
        check_req  = 1'b1;
        wait (!check_req);
    endtask

    // ----------------------------------------------------------
    // transaction log compare for one run at a time
    // ----------------------------------------------------------
    always @(negedge clk)
    begin
        if (check_req)
        begin
            check_value({check_name, " transaction count"}, 8, target.log_count - log_base);
            check_value({check_name, " overlapping go"}, 0, target.overlap_count);
            check_entry({check_name, " adapt on"}, 0, ctrl_op_wr, `DFE_REG11_ADDR);
            check_value({check_name, " adapt on data"}, 16'h8000, logged_wdata(0));
            check_entry({check_name, " reg13 read"}, 1, ctrl_op_rd, `DFE_REG13_ADDR);
            check_entry({check_name, " bypass clear"}, 2, ctrl_op_wr, `DFE_REG13_ADDR);
            check_value({check_name, " bypass clear data"}, reg13_preset & 16'hfffe,
                        logged_wdata(2));
            for (int i = 0; i < 3; i++)
            begin
                check_value({check_name, " select opcode"}, ctrl_op_tbus,
                            target.log_op[log_base + 3 + i]);
                check_value({check_name, " select code"}, 9 + i, logged_wdata(3 + i));
            end
            check_entry({check_name, " reg11 taps"}, 6, ctrl_op_wr, `DFE_REG11_ADDR);
            check_value({check_name, " reg11 data"}, exp_reg11, logged_wdata(6));
            check_entry({check_name, " reg13 restore"}, 7, ctrl_op_wr, `DFE_REG13_ADDR);
            check_value({check_name, " reg13 data"}, exp_reg13, logged_wdata(7));
            // lock covers the register 13 read through the register 11 write
            for (int i = 0; i < 8; i++)
                check_value({check_name, " lock"}, (i >= 1) && (i <= 6),
                            target.log_lock[log_base + i]);
            check_req = 1'b0;
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $fatal(1);
    end

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------
    initial
    begin
        clk           = 1'b0;
        reset         = 1'b1;
        uif           = '0;
        reg13_preset  = '0;
        testbus_bytes = '0;
        err_on_adapt  = 1'b0;
        check_req     = 1'b0;
        seed          = 32'h48c8_fff2;
        rnd           = $urandom(seed);
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        repeat (10)
        begin
            @(negedge clk);
            check_value("idle busy", 0, uif_busy);
            check_value("idle go", 0, ctrl_req.go);
            check_value("idle lock", 0, ctrl_req.lock);
        end

        load_random(24'h0);
        run_adapt("default run", default_cycles);

        // user register writes leave the engine idle
        user_write(`DFE_OFFSET_ADAPT_WAIT, 16'd3);
        @(negedge clk);
        check_value("wait write busy", 0, uif_busy);
        user_write(`DFE_OFFSET_ADAPT_COUNT, 16'd4);
        @(negedge clk);
        check_value("count write busy", 0, uif_busy);
        load_random(24'h0);
        run_adapt("count 4 run", short_cycles);
        check_value("count 4 shorter", 1, short_cycles < default_cycles);

        user_write(`DFE_OFFSET_ADAPT_COUNT, 16'd7);
        load_random(24'h0);
        run_adapt("count 7 run", cycles);

        // every signed tap negative
        load_random(24'h200381);
        run_adapt("negative run", cycles);
        check_value("negative run kept bits", reg13_preset & 16'he1fe,
                    logged_wdata(7) & 16'he1fe);

        // refused adapt-on write ends the run
        @(posedge clk);
        err_on_adapt <= 1'b1;
        log_base = target.log_count;
        user_write(`DFE_OFFSET_TAP_ADAPT, 16'h0000);
        @(negedge clk);
        while (uif_busy)
            @(negedge clk);
        check_value("chan err transactions", 1, target.log_count - log_base);
        repeat (20)
        begin
            @(negedge clk);
            check_value("chan err go", 0, ctrl_req.go);
            check_value("chan err busy", 0, uif_busy);
            check_value("chan err lock", 0, ctrl_req.lock);
        end

        $display("Test passed");
        $finish;
    end

endmodule
